// ==== dv/tb_console.sv ====
`timescale 1ns/1ns

module tb_console;

    localparam int          DATA_LEN    = 8;
    localparam int          SLOT_STRIDE = 'h240;
    localparam int          FIFO_DEPTH  = 4;
    localparam int          TIMEOUT     = 4000;
    localparam logic [31:0] SEED        = 32'h49d1c651;

    logic                   clk;
    logic                   rst;
    logic                   rx_valid;
    logic                   rx_ready;
    logic [7:0]             rx_byte;
    logic                   adc_req;
    console_pkg::adc_op_t   adc_op;
    logic                   adc_done;
    logic                   tx_valid;
    logic                   tx_ready;
    logic                   tx_header;
    console_pkg::btype_t    tx_btype;
    console_pkg::ram_addr_t tx_addr;
    logic                   tx_last;

    // expected frames and ADC operations, in order
    console_pkg::btype_t    exp_btype [$];
    console_pkg::ram_addr_t exp_addr  [$];
    console_pkg::ram_len_t  exp_len   [$];
    console_pkg::adc_op_t   exp_op    [$];

    // frames seen on the transmit port and operations seen by the ADC model
    console_pkg::btype_t    fr_btype [$];
    console_pkg::ram_addr_t fr_addr  [$];
    console_pkg::ram_len_t  fr_len   [$];
    logic                   fr_cont  [$];
    console_pkg::adc_op_t   op_log   [$];

    // reference model of the slot bookkeeping
    console_pkg::data_idx_t ref_prev_idx;
    int                     ref_next_slot;
    int                     ref_last_slot;

    logic [31:0] adc_rng;
    logic [31:0] tx_rng;
    logic [31:0] stim_rng;
    logic        bp_on;
    int          error_count;
    int          test_count;
    int          failed_tests;

    logic                   in_frame = 1'b0;
    console_pkg::btype_t    cur_btype;
    console_pkg::ram_addr_t cur_addr;
    console_pkg::ram_len_t  cur_len;
    logic                   cur_cont;

    adc_console_top #(
        .DATA_LEN    (DATA_LEN),
        .SLOT_STRIDE (SLOT_STRIDE),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) u_adc_console_top (
        .clk       (clk),
        .rst       (rst),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .rx_byte   (rx_byte),
        .adc_req   (adc_req),
        .adc_op    (adc_op),
        .adc_done  (adc_done),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .tx_header (tx_header),
        .tx_btype  (tx_btype),
        .tx_addr   (tx_addr),
        .tx_last   (tx_last)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ADC model, one done pulse per request after 1 to 8 cycles
    initial begin
        adc_done = 1'b0;
        adc_rng  = SEED;
        forever begin
            @(negedge clk);
            if (!rst && adc_req) begin
                op_log.push_back(adc_op);
                adc_rng = lcg_next(adc_rng);
                repeat (1 + int'(adc_rng[30:28])) @(negedge clk);
                adc_done = 1'b1;
                @(negedge clk);
                adc_done = 1'b0;
            end
        end
    end

    initial begin
        tx_ready = 1'b1;
        tx_rng   = SEED;
        forever begin
            @(negedge clk);
            if (bp_on) begin
                tx_rng   = lcg_next(tx_rng);
                tx_ready = tx_rng[29];
            end else begin
                tx_ready = 1'b1;
            end
        end
    end

    task automatic store_frame();
        fr_btype.push_back(cur_btype);
        fr_addr.push_back(cur_addr);
        fr_len.push_back(cur_len);
        fr_cont.push_back(cur_cont);
    endtask

    // frame collector
    always @(posedge clk) begin
        if (!rst && tx_valid && tx_ready) begin
            if (tx_header) begin
                if (in_frame) begin
                    $display("Error at %0t ns: header beat arrived before the frame ended", $time);
                    error_count++;
                end
                cur_btype = tx_btype;
                cur_addr  = tx_addr;
                cur_len   = '0;
                cur_cont  = 1'b1;
                in_frame  = !tx_last;
                if (tx_last) begin
                    store_frame();
                end
            end else if (!in_frame) begin
                $display("Error at %0t ns: address beat arrived outside a frame", $time);
                error_count++;
            end else begin
                if (tx_addr != cur_addr + cur_len) begin
                    cur_cont = 1'b0;
                end
                cur_len = cur_len + 12'd1;
                if (tx_last) begin
                    in_frame = 1'b0;
                    store_frame();
                end
            end
        end
    end

    task automatic abort_run(input string why);
        $display("Timeout at %0t ns: %s", $time, why);
        $display("Regression failed");
        $finish;
    endtask

    task automatic check_btype(input string what, input console_pkg::btype_t got,
                               input console_pkg::btype_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s packet type %0d, expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_addr(input string what, input console_pkg::ram_addr_t got,
                              input console_pkg::ram_addr_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s start address %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_len(input string what, input console_pkg::ram_len_t got,
                             input console_pkg::ram_len_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s beat count %0d, expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_op(input string what, input console_pkg::adc_op_t got,
                            input console_pkg::adc_op_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s ADC operation %s, expected %s",
                     $time, what, got.name(), exp.name());
            error_count++;
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic expect_frame(input console_pkg::btype_t bt, input console_pkg::ram_addr_t addr,
                                input console_pkg::ram_len_t len);
        exp_btype.push_back(bt);
        exp_addr.push_back(addr);
        exp_len.push_back(len);
    endtask

    // reply rules per request type, data index in bits 27 to 24
    task automatic expect_cmd(input console_pkg::btype_t bt, input console_pkg::cmd_t word);
        console_pkg::data_idx_t idx;
        int                     slot;
        idx = word[27:24];
        case (bt)
            console_pkg::BAG_DIDX: begin
                exp_op.push_back(console_pkg::ADC_TYPE);
                expect_frame(console_pkg::BAG_DTYPE, console_pkg::ADDR_DTYPE,
                             console_pkg::SHORT_LEN);
            end
            console_pkg::BAG_DPARAM: begin
                exp_op.push_back(console_pkg::ADC_CONF);
                expect_frame(console_pkg::BAG_DTEMP, console_pkg::ADDR_DTEMP,
                             console_pkg::SHORT_LEN);
            end
            console_pkg::BAG_DDIDX: begin
                if (idx != ref_prev_idx) begin
                    slot          = ref_next_slot;
                    ref_last_slot = slot;
                    ref_next_slot = (ref_next_slot + 1) % console_pkg::NUM_SLOTS;
                    exp_op.push_back(console_pkg::ADC_CONV);
                end else begin
                    slot = ref_last_slot;
                end
                ref_prev_idx = idx;
                expect_frame((slot % 2 == 1) ? console_pkg::BAG_DATA1 : console_pkg::BAG_DATA0,
                             console_pkg::ram_addr_t'(slot * SLOT_STRIDE),
                             console_pkg::ram_len_t'(DATA_LEN));
            end
            default: begin
                expect_frame(console_pkg::BAG_ERROR, '0, '0);
            end
        endcase
    endtask

    task automatic send_byte(input logic [7:0] b);
        int waited;
        waited   = 0;
        @(negedge clk);
        rx_valid = 1'b1;
        rx_byte  = b;
        // ready seen mid cycle, so the byte moves on the next rising edge
        while (!rx_ready) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("receiver never became ready for the next byte");
            end
        end
    endtask

    task automatic release_rx();
        @(negedge clk);
        rx_valid = 1'b0;
        rx_byte  = '0;
    endtask

    task automatic send_packet(input console_pkg::btype_t bt, input console_pkg::cmd_t word);
        send_byte({console_pkg::SYNC_NIBBLE, bt});
        for (int i = 3; i >= 0; i--) begin
            send_byte(word[8*i +: 8]);
        end
        release_rx();
    endtask

    task automatic random_word(input console_pkg::data_idx_t idx, output console_pkg::cmd_t w);
        stim_rng = lcg_next(stim_rng);
        w        = {stim_rng[31:28], idx, stim_rng[23:0]};
    endtask

    task automatic command(input console_pkg::btype_t bt, input console_pkg::data_idx_t idx);
        console_pkg::cmd_t w;
        random_word(idx, w);
        expect_cmd(bt, w);
        send_packet(bt, w);
    endtask

    task automatic drain_frames(input string name);
        int waited;
        waited = 0;
        while (fr_btype.size() < exp_btype.size()) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run($sformatf("%s got %0d of %0d frames", name, fr_btype.size(),
                                    exp_btype.size()));
            end
        end
        while (exp_btype.size() > 0) begin
            check_btype(name, fr_btype.pop_front(), exp_btype.pop_front());
            check_addr(name, fr_addr.pop_front(), exp_addr.pop_front());
            check_len(name, fr_len.pop_front(), exp_len.pop_front());
            if (!fr_cont.pop_front()) begin
                $display("Error at %0t ns: %s frame addresses do not count up by one", $time, name);
                error_count++;
            end
        end
        if (fr_btype.size() != 0) begin
            $display("Error at %0t ns: %s produced %0d unexpected frames", $time, name,
                     fr_btype.size());
            error_count++;
            fr_btype.delete();
            fr_addr.delete();
            fr_len.delete();
            fr_cont.delete();
        end
        if (op_log.size() != exp_op.size()) begin
            $display("Error at %0t ns: %s saw %0d ADC operations, expected %0d", $time, name,
                     op_log.size(), exp_op.size());
            error_count++;
        end
        while (op_log.size() > 0 && exp_op.size() > 0) begin
            check_op(name, op_log.pop_front(), exp_op.pop_front());
        end
        op_log.delete();
        exp_op.delete();
    endtask

    task automatic log_test_result(input string name, input int start_errors);
        int errs;
        errs = error_count - start_errors;
        test_count++;
        if (errs != 0) begin
            failed_tests++;
        end
        $display("test %-16s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    task automatic startup_link();
        int start;
        start = error_count;
        exp_op.push_back(console_pkg::ADC_INIT);
        expect_frame(console_pkg::BAG_DLINK, console_pkg::ADDR_DLINK, console_pkg::SHORT_LEN);
        repeat (16) @(negedge clk);
        check_level("rx_ready in reset", rx_ready, 1'b0);
        check_level("adc_req in reset", adc_req, 1'b0);
        check_level("tx_valid in reset", tx_valid, 1'b0);
        rst = 1'b0;
        drain_frames("startup");
        log_test_result("startup", start);
    endtask

    task automatic device_commands();
        int start;
        start = error_count;
        command(console_pkg::BAG_DIDX, 4'd0);
        command(console_pkg::BAG_DPARAM, 4'd0);
        drain_frames("device");
        log_test_result("device", start);
    endtask

    task automatic data_index_sequence();
        console_pkg::data_idx_t idx_list [8];
        int                     start;
        start    = error_count;
        idx_list = '{4'd3, 4'd3, 4'd5, 4'd1, 4'd2, 4'd4, 4'd6, 4'd7};
        for (int i = 0; i < 8; i++) begin
            command(console_pkg::BAG_DDIDX, idx_list[i]);
        end
        drain_frames("data_index");
        log_test_result("data_index", start);
    endtask

    task automatic framing_errors();
        int start;
        start = error_count;
        // stray bytes without the sync nibble
        send_byte(8'h37);
        send_byte(8'h5C);
        release_rx();
        command(console_pkg::BAG_DPARAM, 4'd0);
        command(console_pkg::btype_t'(4'd2), 4'd0);
        drain_frames("framing");
        log_test_result("framing", start);
    endtask

    task automatic backpressure_order();
        console_pkg::btype_t    bt_list  [7];
        console_pkg::data_idx_t idx_list [7];
        int                     start;
        start    = error_count;
        bt_list  = '{console_pkg::BAG_DDIDX, console_pkg::BAG_DIDX, console_pkg::BAG_DDIDX,
                     console_pkg::btype_t'(4'd3), console_pkg::BAG_DDIDX,
                     console_pkg::BAG_DPARAM, console_pkg::BAG_DDIDX};
        idx_list = '{4'd9, 4'd0, 4'd9, 4'd0, 4'd0, 4'd0, 4'd10};
        bp_on    = 1'b1;
        for (int i = 0; i < 7; i++) begin
            command(bt_list[i], idx_list[i]);
        end
        drain_frames("backpressure");
        bp_on = 1'b0;
        log_test_result("backpressure", start);
    endtask

    initial begin
        rst           = 1'b1;
        rx_valid      = 1'b0;
        rx_byte       = '0;
        bp_on         = 1'b0;
        stim_rng      = SEED;
        error_count   = 0;
        test_count    = 0;
        failed_tests  = 0;
        ref_prev_idx  = 4'd8;
        ref_next_slot = 0;
        ref_last_slot = 0;

        startup_link();
        device_commands();
        data_index_sequence();
        framing_errors();
        backpressure_order();

        $display("summary: %0d tests, %0d failed, %0d errors", test_count, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_console -f tb.f -o tb_console \
    && ./obj_dir/tb_console > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

// ==== src/adc_console_top.sv ====
`timescale 1ns/1ns

module adc_console_top #(
    parameter int DATA_LEN    = 'h202,
    parameter int SLOT_STRIDE = 'h240,
    parameter int FIFO_DEPTH  = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rx_valid,
    output logic                   rx_ready,
    input  logic [7:0]             rx_byte,
    output logic                   adc_req,
    output console_pkg::adc_op_t   adc_op,
    input  logic                   adc_done,
    output logic                   tx_valid,
    input  logic                   tx_ready,
    output logic                   tx_header,
    output console_pkg::btype_t    tx_btype,
    output console_pkg::ram_addr_t tx_addr,
    output logic                   tx_last
);

    logic                   cmd_valid;
    logic                   cmd_ready;
    console_pkg::btype_t    cmd_btype;
    console_pkg::cmd_t      cmd_word;

    logic                   desc_valid;
    logic                   desc_ready;
    console_pkg::btype_t    desc_btype;
    console_pkg::ram_addr_t desc_addr;
    console_pkg::ram_len_t  desc_len;

    logic                   q_valid;
    logic                   q_ready;
    console_pkg::btype_t    q_btype;
    console_pkg::ram_addr_t q_addr;
    console_pkg::ram_len_t  q_len;

    cmd_receiver u_cmd_receiver (
        .clk       (clk),
        .rst       (rst),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .rx_byte   (rx_byte),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_btype (cmd_btype),
        .cmd_word  (cmd_word)
    );

    console #(
        .DATA_LEN    (DATA_LEN),
        .SLOT_STRIDE (SLOT_STRIDE)
    ) u_console (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_btype  (cmd_btype),
        .cmd_word   (cmd_word),
        .adc_req    (adc_req),
        .adc_op     (adc_op),
        .adc_done   (adc_done),
        .desc_valid (desc_valid),
        .desc_ready (desc_ready),
        .desc_btype (desc_btype),
        .desc_addr  (desc_addr),
        .desc_len   (desc_len)
    );

    desc_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_desc_fifo (
        .clk        (clk),
        .rst        (rst),
        .desc_valid (desc_valid),
        .desc_ready (desc_ready),
        .desc_btype (desc_btype),
        .desc_addr  (desc_addr),
        .desc_len   (desc_len),
        .q_valid    (q_valid),
        .q_ready    (q_ready),
        .q_btype    (q_btype),
        .q_addr     (q_addr),
        .q_len      (q_len)
    );

    frame_sender u_frame_sender (
        .clk       (clk),
        .rst       (rst),
        .q_valid   (q_valid),
        .q_ready   (q_ready),
        .q_btype   (q_btype),
        .q_addr    (q_addr),
        .q_len     (q_len),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .tx_header (tx_header),
        .tx_btype  (tx_btype),
        .tx_addr   (tx_addr),
        .tx_last   (tx_last)
    );

endmodule

// ==== src/cmd_receiver.sv ====
`timescale 1ns/1ns

module cmd_receiver (
    input  logic                clk,
    input  logic                rst,
    input  logic                rx_valid,
    output logic                rx_ready,
    input  logic [7:0]          rx_byte,
    output logic                cmd_valid,
    input  logic                cmd_ready,
    output console_pkg::btype_t cmd_btype,
    output console_pkg::cmd_t   cmd_word
);

    typedef enum logic [1:0] {
        HUNT,
        BYTES,
        HOLD
    } rx_state_t;

    rx_state_t  state;
    rx_state_t  next_state;
    logic [1:0] byte_cnt;
    logic       rx_fire;

    assign rx_fire   = rx_valid && rx_ready;
    assign cmd_valid = (state == HOLD);

    always_comb begin
        next_state = state;
        case (state)
            HUNT: begin
                // bad sync nibble just drops the byte
                if (rx_fire && rx_byte[7:4] == console_pkg::SYNC_NIBBLE) begin
                    next_state = BYTES;
                end
            end
            BYTES: begin
                if (rx_fire && byte_cnt == 2'd3) begin
                    next_state = HOLD;
                end
            end
            HOLD: begin
                if (cmd_ready) begin
                    next_state = HUNT;
                end
            end
            default: begin
                next_state = HUNT;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= HUNT;
            rx_ready <= 1'b0;
            byte_cnt <= 2'd0;
        end else begin
            state    <= next_state;
            rx_ready <= (next_state != HOLD);
            if (state != BYTES) begin
                byte_cnt <= 2'd0;
            end else if (rx_fire) begin
                byte_cnt <= byte_cnt + 2'd1;
            end
        end
    end

    // msb first into the command word
    always_ff @(posedge clk) begin
        if (state == HUNT && rx_fire) begin
            cmd_btype <= rx_byte[3:0];
        end
        if (state == BYTES && rx_fire) begin
            cmd_word <= {cmd_word[23:0], rx_byte};
        end
    end

    a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> $stable(cmd_word) && $stable(cmd_btype));

endmodule

// ==== src/console.sv ====
`timescale 1ns/1ns

module console #(
    parameter int DATA_LEN    = 'h202,
    parameter int SLOT_STRIDE = 'h240
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  console_pkg::btype_t    cmd_btype,
    input  console_pkg::cmd_t      cmd_word,
    output logic                   adc_req,
    output console_pkg::adc_op_t   adc_op,
    input  logic                   adc_done,
    output logic                   desc_valid,
    input  logic                   desc_ready,
    output console_pkg::btype_t    desc_btype,
    output console_pkg::ram_addr_t desc_addr,
    output console_pkg::ram_len_t  desc_len
);

    localparam int BOOT_WAIT = 12;

    typedef enum logic [2:0] {
        S_BOOT,
        S_ADC,
        S_IDLE,
        S_TAKE,
        S_DEC,
        S_DESC
    } state_t;

    state_t                  state;
    state_t                  next_state;
    logic [3:0]              boot_cnt;
    logic                    boot_done;
    console_pkg::btype_t     req_btype;
    console_pkg::data_idx_t  req_idx;
    console_pkg::data_idx_t  prev_idx;
    logic [2:0]              next_slot;
    logic [2:0]              last_slot;
    logic [2:0]              use_slot;
    console_pkg::ram_addr_t  slot_addr;
    logic                    new_idx;
    logic                    needs_adc;

    assign cmd_ready  = (state == S_TAKE);
    assign adc_req    = (state == S_ADC);
    assign desc_valid = (state == S_DESC);

    assign boot_done = (boot_cnt == 4'(BOOT_WAIT - 1));
    assign new_idx   = (req_idx != prev_idx);
    // a repeated index points back at the slot filled last
    assign use_slot  = new_idx ? next_slot : last_slot;
    assign slot_addr = console_pkg::ram_addr_t'(use_slot * SLOT_STRIDE);

    always_comb begin
        case (req_btype)
            console_pkg::BAG_DIDX:   needs_adc = 1'b1;
            console_pkg::BAG_DPARAM: needs_adc = 1'b1;
            console_pkg::BAG_DDIDX:  needs_adc = new_idx;
            default:                 needs_adc = 1'b0;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            S_BOOT: begin
                if (boot_done) begin
                    next_state = S_ADC;
                end
            end
            S_ADC: begin
                if (adc_done) begin
                    next_state = S_DESC;
                end
            end
            S_DESC: begin
                if (desc_ready) begin
                    next_state = S_IDLE;
                end
            end
            S_IDLE: begin
                if (cmd_valid) begin
                    next_state = S_TAKE;
                end
            end
            S_TAKE: begin
                next_state = S_DEC;
            end
            S_DEC: begin
                next_state = needs_adc ? S_ADC : S_DESC;
            end
            default: begin
                next_state = S_BOOT;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_BOOT;
            boot_cnt  <= 4'd0;
            prev_idx  <= 4'd8;
            next_slot <= 3'd0;
            last_slot <= 3'd0;
        end else begin
            state <= next_state;
            if (state == S_BOOT) begin
                boot_cnt <= boot_cnt + 4'd1;
            end
            if (state == S_DEC && req_btype == console_pkg::BAG_DDIDX) begin
                prev_idx <= req_idx;
                if (new_idx) begin
                    last_slot <= next_slot;
                    if (next_slot == 3'(console_pkg::NUM_SLOTS - 1)) begin
                        next_slot <= 3'd0;
                    end else begin
                        next_slot <= next_slot + 3'd1;
                    end
                end
            end
        end
    end

    // operation and reply fields, valid whenever adc_req or desc_valid is up
    always_ff @(posedge clk) begin
        if (state == S_BOOT && boot_done) begin
            adc_op     <= console_pkg::ADC_INIT;
            desc_btype <= console_pkg::BAG_DLINK;
            desc_addr  <= console_pkg::ADDR_DLINK;
            desc_len   <= console_pkg::SHORT_LEN;
        end
        if (state == S_TAKE) begin
            req_btype <= cmd_btype;
            req_idx   <= cmd_word[console_pkg::DATA_IDX_LSB +: 4];
        end
        if (state == S_DEC) begin
            case (req_btype)
                console_pkg::BAG_DIDX: begin
                    adc_op     <= console_pkg::ADC_TYPE;
                    desc_btype <= console_pkg::BAG_DTYPE;
                    desc_addr  <= console_pkg::ADDR_DTYPE;
                    desc_len   <= console_pkg::SHORT_LEN;
                end
                console_pkg::BAG_DPARAM: begin
                    adc_op     <= console_pkg::ADC_CONF;
                    desc_btype <= console_pkg::BAG_DTEMP;
                    desc_addr  <= console_pkg::ADDR_DTEMP;
                    desc_len   <= console_pkg::SHORT_LEN;
                end
                console_pkg::BAG_DDIDX: begin
                    adc_op     <= console_pkg::ADC_CONV;
                    desc_btype <= use_slot[0] ? console_pkg::BAG_DATA1
                                              : console_pkg::BAG_DATA0;
                    desc_addr  <= slot_addr;
                    desc_len   <= console_pkg::ram_len_t'(DATA_LEN);
                end
                default: begin
                    desc_btype <= console_pkg::BAG_ERROR;
                    desc_addr  <= '0;
                    desc_len   <= '0;
                end
            endcase
        end
    end

    a_req_desc_excl: assert property (@(posedge clk) disable iff (rst)
        !(adc_req && desc_valid));

endmodule

// ==== src/console_pkg.sv ====
package console_pkg;

    // packet type carried in the low nibble of a header byte
    typedef logic [3:0] btype_t;

    // request types from the host
    localparam btype_t BAG_DIDX   = 4'd5;
    localparam btype_t BAG_DPARAM = 4'd6;
    localparam btype_t BAG_DDIDX  = 4'd7;

    // reply types back to the host
    localparam btype_t BAG_DLINK = 4'd8;
    localparam btype_t BAG_DTYPE = 4'd9;
    localparam btype_t BAG_DTEMP = 4'd10;
    localparam btype_t BAG_DATA0 = 4'd13;
    localparam btype_t BAG_DATA1 = 4'd14;
    localparam btype_t BAG_ERROR = 4'd15;

    typedef logic [11:0] ram_addr_t;
    typedef logic [11:0] ram_len_t;

    // fixed reply buffers at the top of RAM
    localparam ram_addr_t ADDR_DLINK = 12'hFCC;
    localparam ram_addr_t ADDR_DTYPE = 12'hFC0;
    localparam ram_addr_t ADDR_DTEMP = 12'hFC4;

    localparam ram_len_t SHORT_LEN = 12'd2;

    typedef logic [31:0] cmd_t;
    typedef logic [3:0]  data_idx_t;

    // data index field position inside the command word
    localparam int DATA_IDX_LSB = 24;

    typedef enum logic [1:0] {
        ADC_INIT,
        ADC_TYPE,
        ADC_CONF,
        ADC_CONV
    } adc_op_t;

    localparam logic [3:0] SYNC_NIBBLE = 4'hA;

    localparam int NUM_SLOTS = 6;

endpackage

// ==== src/desc_fifo.sv ====
`timescale 1ns/1ns

module desc_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   desc_valid,
    output logic                   desc_ready,
    input  console_pkg::btype_t    desc_btype,
    input  console_pkg::ram_addr_t desc_addr,
    input  console_pkg::ram_len_t  desc_len,
    output logic                   q_valid,
    input  logic                   q_ready,
    output console_pkg::btype_t    q_btype,
    output console_pkg::ram_addr_t q_addr,
    output console_pkg::ram_len_t  q_len
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    console_pkg::btype_t    btype_mem [DEPTH];
    console_pkg::ram_addr_t addr_mem  [DEPTH];
    console_pkg::ram_len_t  len_mem   [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    // pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign desc_ready = (count != CNT_W'(DEPTH));
    assign q_valid    = (count != '0);
    assign wr_en      = desc_valid && desc_ready;
    assign rd_en      = q_valid && q_ready;

    assign q_btype = btype_mem[rd_ptr];
    assign q_addr  = addr_mem[rd_ptr];
    assign q_len   = len_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            btype_mem[wr_ptr] <= desc_btype;
            addr_mem[wr_ptr]  <= desc_addr;
            len_mem[wr_ptr]   <= desc_len;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        count == '0 |=> count <= CNT_W'(1));

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        count == CNT_W'(DEPTH) |=> count >= CNT_W'(DEPTH - 1) && count <= CNT_W'(DEPTH));

endmodule

// ==== src/frame_sender.sv ====
`timescale 1ns/1ns

module frame_sender (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   q_valid,
    output logic                   q_ready,
    input  console_pkg::btype_t    q_btype,
    input  console_pkg::ram_addr_t q_addr,
    input  console_pkg::ram_len_t  q_len,
    output logic                   tx_valid,
    input  logic                   tx_ready,
    output logic                   tx_header,
    output console_pkg::btype_t    tx_btype,
    output console_pkg::ram_addr_t tx_addr,
    output logic                   tx_last
);

    typedef enum logic [1:0] {
        IDLE,
        HEAD,
        BODY
    } tx_state_t;

    tx_state_t             state;
    console_pkg::btype_t   frame_btype;
    console_pkg::ram_addr_t addr_cnt;
    console_pkg::ram_len_t remain;
    logic                  tx_fire;

    assign q_ready   = (state == IDLE);
    assign tx_valid  = (state != IDLE);
    assign tx_header = (state == HEAD);
    assign tx_btype  = frame_btype;
    assign tx_addr   = addr_cnt;
    assign tx_fire   = tx_valid && tx_ready;

    // zero length frames end on the header
    assign tx_last = (state == HEAD) ? (remain == '0)
                                     : (state == BODY && remain == 12'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (q_valid) begin
                        state <= HEAD;
                    end
                end
                HEAD: begin
                    if (tx_fire) begin
                        state <= (remain == '0) ? IDLE : BODY;
                    end
                end
                BODY: begin
                    if (tx_fire && remain == 12'd1) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && q_valid) begin
            frame_btype <= q_btype;
            addr_cnt    <= q_addr;
            remain      <= q_len;
        end else if (state == BODY && tx_fire) begin
            addr_cnt <= addr_cnt + 12'd1;
            remain   <= remain - 12'd1;
        end
    end

endmodule

// ==== tb.f ====
src/console_pkg.sv
src/cmd_receiver.sv
src/console.sv
src/desc_fifo.sv
src/frame_sender.sv
src/adc_console_top.sv
dv/tb_console.sv
